/* src.f */
async_fifo_pkg.sv
fifo_ram.sv
ptr_sync.sv
fifo_wr_ctrl.sv
fifo_rd_ctrl.sv
async_fifo.sv
tb_async_fifo.sv

/* run_sim.sh */
#!/bin/sh
# build the dual-clock fifo testbench with verilator and run it
# the exit status is the simulator's, a $fatal gives a failing status

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_async_fifo -o sim_tb &&
./obj_dir/sim_tb &&
echo "simulation finished without errors" ||
{ echo "simulation or build failed"; exit 1; }

/* tb_async_fifo.sv */
// testbench for the dual-clock fifo, checks every popped word against a queue model
`timescale 1ns/1ps

module tb_async_fifo;

    import async_fifo_pkg::*;

    localparam int          SYNC_STAGES  = 2;
    localparam int          STREAM_WORDS = 500;
    localparam int          RCLK_PERIOD  = 16;
    localparam logic [31:0] LFSR_SEED    = 32'h323d_4ef5;
    // rclk cycles per test: reset, single, fill, drain, stream
    localparam int EST_CYCLES  = 20 + 20 + 2 * FIFO_DEPTH + 2 * FIFO_DEPTH + 3 * STREAM_WORDS;
    localparam int WATCHDOG_NS = EST_CYCLES * 4 * RCLK_PERIOD;

    logic  rst_n_i;
    logic  wclk;
    logic  wr_en_i;
    data_t wr_data_i;
    logic  full_o;
    logic  rclk;
    logic  rd_en_i;
    data_t rd_data_o;
    logic  rd_valid_o;
    logic  empty_o;

    data_t       model_q [$];  // words written but not yet popped
    logic [31:0] lfsr_q;
    logic        rd_pending;   // a pop was accepted at the last rclk edge
    data_t       rd_expect;
    string       cur_test;

    async_fifo #(
        .SYNC_STAGES (SYNC_STAGES)
    ) dut0 (
        .rst_n_i    (rst_n_i),
        .wclk       (wclk),
        .wr_en_i    (wr_en_i),
        .wr_data_i  (wr_data_i),
        .full_o     (full_o),
        .rclk       (rclk),
        .rd_en_i    (rd_en_i),
        .rd_data_o  (rd_data_o),
        .rd_valid_o (rd_valid_o),
        .empty_o    (empty_o)
    );

    always #5 wclk = ~wclk;

    // odd phase keeps rclk falling edges away from wclk falling edges
    always begin
        #3;
        forever #(RCLK_PERIOD / 2) rclk = ~rclk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0]; // x^32 + x^22 + x^2 + x + 1
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
    endtask

    task automatic report_value(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        $display("ERR %s %s expected %0h actual %0h", cur_test, what, exp, act);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_text(input string msg);
        $display("%s: %s", cur_test, msg);
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    // full_o is stable between the falling and the next rising wclk edge
    task automatic write_cycle(input logic en, input data_t d, output logic taken);
        @(negedge wclk);
        wr_en_i   = en;
        wr_data_i = d;
        taken     = en && (full_o === 1'b0);
        if (taken) begin
            model_q.push_back(d);
        end
    endtask

    // checks the pop of the previous rclk edge, then drives rd_en_i for the next one
    task automatic read_cycle(input logic en);
        @(negedge rclk);
        if (rd_pending) begin
            assert (rd_valid_o === 1'b1)
                else report_value("rd_valid_o", 32'd1, 32'(rd_valid_o));
            assert (rd_data_o === rd_expect)
                else report_value("rd_data_o", 32'(rd_expect), 32'(rd_data_o));
        end else begin
            assert (rd_valid_o === 1'b0)
                else report_value("rd_valid_o", 32'd0, 32'(rd_valid_o));
        end
        rd_en_i    = en;
        rd_pending = en && (empty_o === 1'b0);
        if (rd_pending) begin
            assert (model_q.size() > 0) else report_text("pop while the model queue is empty");
            rd_expect = model_q.pop_front();
        end
    endtask

    task automatic wait_not_empty(input int max_cycles);
        int n;
        n = 0;
        while (empty_o === 1'b1 && n < max_cycles) begin
            read_cycle(1'b0);
            n++;
        end
        assert (empty_o === 1'b0) else report_text("empty_o did not fall in time");
    endtask

    task automatic test_reset();
        logic taken;
        cur_test = "test_reset";
        write_cycle(1'b0, '0, taken);
        assert (full_o === 1'b0) else report_value("full_o", 32'd0, 32'(full_o));
        assert (empty_o === 1'b1) else report_value("empty_o", 32'd1, 32'(empty_o));
        assert (rd_valid_o === 1'b0) else report_value("rd_valid_o", 32'd0, 32'(rd_valid_o));
        assert (rd_data_o === '0) else report_value("rd_data_o", 32'd0, 32'(rd_data_o));
        repeat (3) read_cycle(1'b1); // ignored while empty
        read_cycle(1'b0);
        assert (empty_o === 1'b1) else report_value("empty_o", 32'd1, 32'(empty_o));
    endtask

    task automatic test_single();
        logic        taken;
        logic [31:0] r;
        cur_test = "test_single";
        take_bits(8, r);
        write_cycle(1'b1, r[7:0], taken);
        assert (taken) else report_text("single write was refused");
        write_cycle(1'b0, '0, taken);
        wait_not_empty(8);
        read_cycle(1'b1);
        read_cycle(1'b0);
        assert (empty_o === 1'b1) else report_value("empty_o", 32'd1, 32'(empty_o));
        assert (model_q.size() == 0) else report_value("queue size", 32'd0, model_q.size());
    endtask

    task automatic test_fill();
        logic        taken;
        logic [31:0] r;
        cur_test = "test_fill";
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            take_bits(8, r);
            write_cycle(1'b1, r[7:0], taken);
            assert (taken) else report_text("write refused before the fifo was full");
        end
        write_cycle(1'b0, '0, taken);
        assert (full_o === 1'b1) else report_value("full_o", 32'd1, 32'(full_o));
        for (int i = 0; i < 4; i++) begin
            take_bits(8, r);
            write_cycle(1'b1, r[7:0], taken);
            assert (!taken) else report_text("write accepted while full");
        end
        write_cycle(1'b0, '0, taken);
        assert (model_q.size() == FIFO_DEPTH)
            else report_value("queue size", FIFO_DEPTH, model_q.size());
    endtask

    task automatic test_drain();
        int popped;
        int n;
        cur_test = "test_drain";
        popped = 0;
        n      = 0;
        while (popped < FIFO_DEPTH && n < 4 * FIFO_DEPTH) begin
            read_cycle(1'b1);
            if (rd_pending) begin
                popped++;
            end
            n++;
        end
        assert (popped == FIFO_DEPTH) else report_value("words popped", FIFO_DEPTH, popped);
        read_cycle(1'b0); // checks the final pop
        assert (empty_o === 1'b1) else report_value("empty_o", 32'd1, 32'(empty_o));
        repeat (3) read_cycle(1'b1);
        read_cycle(1'b0);
        assert (model_q.size() == 0) else report_value("queue size", 32'd0, model_q.size());
    endtask

    task automatic test_stream();
        int          sent;
        int          got;
        logic        taken;
        logic        wen;
        logic [31:0] rw;
        logic [31:0] rr;
        cur_test = "test_stream";
        sent = 0;
        got  = 0;
        fork
            begin
                while (sent < STREAM_WORDS) begin
                    take_bits(1, rw);
                    wen = rw[0];
                    take_bits(8, rw);
                    write_cycle(wen, rw[7:0], taken);
                    if (taken) begin
                        sent++;
                    end
                end
                write_cycle(1'b0, '0, taken);
            end
            begin
                while (got < STREAM_WORDS) begin
                    take_bits(2, rr);
                    read_cycle(rr[1:0] != 2'b00); // read enable three times in four
                    if (rd_pending) begin
                        got++;
                    end
                end
                read_cycle(1'b0);
            end
        join
        assert (empty_o === 1'b1) else report_value("empty_o", 32'd1, 32'(empty_o));
        assert (model_q.size() == 0) else report_value("queue size", 32'd0, model_q.size());
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

    initial begin
        wclk       = 1'b0;
        rclk       = 1'b0;
        rst_n_i    = 1'b0;
        wr_en_i    = 1'b0;
        wr_data_i  = '0;
        rd_en_i    = 1'b0;
        lfsr_q     = LFSR_SEED;
        rd_pending = 1'b0;
        rd_expect  = '0;
        cur_test   = "reset";
        repeat (8) @(negedge wclk);
        rst_n_i = 1'b1;
        test_reset();
        test_single();
        test_fill();
        test_drain();
        test_stream();
        $display("** PASS **");
        $finish;
    end

endmodule

/* async_fifo.sv */
// dual-clock fifo top level joining the controllers, the ram and the pointer synchronizers
`timescale 1ns/1ps

module async_fifo #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                  rst_n_i,

    input  logic                  wclk,
    input  logic                  wr_en_i,
    input  async_fifo_pkg::data_t wr_data_i,
    output logic                  full_o,

    input  logic                  rclk,
    input  logic                  rd_en_i,
    output async_fifo_pkg::data_t rd_data_o,
    output logic                  rd_valid_o,
    output logic                  empty_o
);

    import async_fifo_pkg::*;

    ram_wr_t wr_req;
    addr_t   rd_addr;
    logic    ram_rd_en;

    ptr_t    wptr_gray;     // wclk domain
    ptr_t    rptr_gray;     // rclk domain
    ptr_t    wptr_bin_sync; // write pointer seen in rclk
    ptr_t    rptr_bin_sync; // read pointer seen in wclk

    fifo_wr_ctrl u_wr_ctrl (
        .wclk            (wclk),
        .rst_n_i         (rst_n_i),
        .wr_en_i         (wr_en_i),
        .wr_data_i       (wr_data_i),
        .rptr_bin_sync_i (rptr_bin_sync),
        .wr_req_o        (wr_req),
        .wptr_gray_o     (wptr_gray),
        .full_o          (full_o)
    );

    fifo_rd_ctrl u_rd_ctrl (
        .rclk            (rclk),
        .rst_n_i         (rst_n_i),
        .rd_en_i         (rd_en_i),
        .wptr_bin_sync_i (wptr_bin_sync),
        .ram_rd_en_o     (ram_rd_en),
        .rd_addr_o       (rd_addr),
        .rptr_gray_o     (rptr_gray),
        .empty_o         (empty_o),
        .rd_valid_o      (rd_valid_o)
    );

    fifo_ram u_ram (
        .wclk      (wclk),
        .rclk      (rclk),
        .wr_req_i  (wr_req),
        .rd_en_i   (ram_rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data_o),
        .rst_n_i   (rst_n_i)
    );

    // read pointer into the write domain, feeds the full flag
    ptr_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_r2w (
        .dst_clk (wclk),
        .rst_n_i (rst_n_i),
        .gray_i  (rptr_gray),
        .bin_o   (rptr_bin_sync)
    );

    // write pointer into the read domain, feeds the empty flag
    ptr_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_w2r (
        .dst_clk (rclk),
        .rst_n_i (rst_n_i),
        .gray_i  (wptr_gray),
        .bin_o   (wptr_bin_sync)
    );

endmodule

/* fifo_rd_ctrl.sv */
// read side controller: binary and gray read pointers, empty flag and read valid
`timescale 1ns/1ps

module fifo_rd_ctrl (
    input  logic                  rclk,
    input  logic                  rst_n_i,
    input  logic                  rd_en_i,
    input  async_fifo_pkg::ptr_t  wptr_bin_sync_i,
    output logic                  ram_rd_en_o,
    output async_fifo_pkg::addr_t rd_addr_o,
    output async_fifo_pkg::ptr_t  rptr_gray_o,
    output logic                  empty_o,
    output logic                  rd_valid_o
);

    import async_fifo_pkg::*;

    ptr_t rptr_q;
    ptr_t rptr_next;
    logic rd_fire;
    logic empty_next;

    assign rd_fire = rd_en_i & ~empty_o;

    always_comb begin
        rptr_next  = rptr_q + ptr_t'(rd_fire);
        empty_next = (rptr_next == wptr_bin_sync_i);
    end

    // the ram loads its output register on the same edge as the pop
    assign ram_rd_en_o = rd_fire;
    assign rd_addr_o   = rptr_q[ADDR_W-1:0];

    always_ff @(posedge rclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rptr_q      <= '0;
            rptr_gray_o <= '0;
            empty_o     <= 1'b1;
            rd_valid_o  <= 1'b0;
        end else begin
            rptr_q      <= rptr_next;
            rptr_gray_o <= bin2gray(rptr_next);
            empty_o     <= empty_next;
            rd_valid_o  <= rd_fire; // one pulse per popped word
        end
    end

    // gray pointer crossing into wclk must stay single-bit per step
    a_rgray_one_bit: assert property (
        @(posedge rclk) disable iff (!rst_n_i)
        $onehot0(rptr_gray_o ^ $past(rptr_gray_o))
    ) else $error("read gray pointer moved by more than one bit");

    // nothing can be popped out of a cycle in which the fifo was empty
    a_no_valid_after_empty: assert property (
        @(posedge rclk) disable iff (!rst_n_i)
        (rptr_q == wptr_bin_sync_i) |=> !rd_valid_o
    ) else $error("rd_valid_o raised after an empty cycle");

endmodule

/* fifo_wr_ctrl.sv */
// write side controller: binary and gray write pointers, full flag, ram write request
`timescale 1ns/1ps

module fifo_wr_ctrl (
    input  logic                    wclk,
    input  logic                    rst_n_i,
    input  logic                    wr_en_i,
    input  async_fifo_pkg::data_t   wr_data_i,
    input  async_fifo_pkg::ptr_t    rptr_bin_sync_i,
    output async_fifo_pkg::ram_wr_t wr_req_o,
    output async_fifo_pkg::ptr_t    wptr_gray_o,
    output logic                    full_o
);

    import async_fifo_pkg::*;

    ptr_t wptr_q;
    ptr_t wptr_next;
    ptr_t wr_level;   // words held, as seen through the synced read pointer
    logic wr_fire;
    logic full_next;

    assign wr_fire = wr_en_i & ~full_o;

    always_comb begin
        wptr_next = wptr_q + ptr_t'(wr_fire);
        wr_level  = ptr_t'(wptr_next - rptr_bin_sync_i);
        full_next = (wr_level == ptr_t'(FIFO_DEPTH));
    end

    // ram address comes from the current pointer, before the increment
    always_comb begin
        wr_req_o.wen   = wr_fire;
        wr_req_o.waddr = wptr_q[ADDR_W-1:0];
        wr_req_o.wdata = wr_data_i;
    end

    always_ff @(posedge wclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wptr_q      <= '0;
            wptr_gray_o <= '0;
            full_o      <= 1'b1; // block writes until first clock after reset
        end else begin
            wptr_q      <= wptr_next;
            wptr_gray_o <= bin2gray(wptr_next);
            full_o      <= full_next;
        end
    end

    // gray pointer seen by rclk domain may only flip one bit at a time
    a_wgray_one_bit: assert property (
        @(posedge wclk) disable iff (!rst_n_i)
        $onehot0(wptr_gray_o ^ $past(wptr_gray_o))
    ) else $error("write gray pointer moved by more than one bit");

    // no word may land in the ram while the fifo already holds FIFO_DEPTH words
    a_no_write_when_full: assert property (
        @(posedge wclk) disable iff (!rst_n_i)
        (ptr_t'(wptr_q - rptr_bin_sync_i) == ptr_t'(FIFO_DEPTH)) |-> !wr_req_o.wen
    ) else $error("ram write issued while full");

endmodule

/* ptr_sync.sv */
// gray pointer synchronizer with gray to binary conversion in the destination clock
`timescale 1ns/1ps

module ptr_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                 dst_clk,
    input  logic                 rst_n_i,
    input  async_fifo_pkg::ptr_t gray_i,
    output async_fifo_pkg::ptr_t bin_o
);

    import async_fifo_pkg::*;

    ptr_t sync_q [SYNC_STAGES];
    ptr_t gray_sync;

    always_ff @(posedge dst_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= gray_i; // only metastable stage
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign gray_sync = sync_q[SYNC_STAGES-1];

    // prefix xor from the msb down
    always_comb begin
        bin_o[PTR_W-1] = gray_sync[PTR_W-1];
        for (int i = PTR_W - 2; i >= 0; i--) begin
            bin_o[i] = bin_o[i+1] ^ gray_sync[i];
        end
    end

endmodule

/* fifo_ram.sv */
// dual-port fifo storage, written on wclk and read through a register on rclk
`timescale 1ns/1ps

module fifo_ram (
    input  logic                    wclk,
    input  logic                    rclk,
    input  async_fifo_pkg::ram_wr_t wr_req_i,
    input  logic                    rd_en_i,
    input  async_fifo_pkg::addr_t   rd_addr_i,
    output async_fifo_pkg::data_t   rd_data_o,
    input  logic                    rst_n_i
);

    import async_fifo_pkg::*;

    data_t mem [FIFO_DEPTH];

    always_ff @(posedge wclk) begin
        if (wr_req_i.wen) begin
            mem[wr_req_i.waddr] <= wr_req_i.wdata;
        end
    end

    // output word only moves on an accepted pop
    always_ff @(posedge rclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

/* async_fifo_pkg.sv */
// async fifo package with sizes, word and pointer types, and the ram write request
package async_fifo_pkg;

    // FIFO_DEPTH must be a power of two so the wrap bit works
    parameter int FIFO_DEPTH = 32;
    parameter int DATA_W     = 8;
    parameter int ADDR_W     = $clog2(FIFO_DEPTH);
    parameter int PTR_W      = ADDR_W + 1; // address plus wrap bit

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [PTR_W-1:0]  ptr_t;  // binary or gray pointer

    // write request from the wclk controller into the ram
    typedef struct packed {
        logic  wen;
        addr_t waddr;
        data_t wdata;
    } ram_wr_t;

    // binary to gray, used by both pointer controllers
    function automatic ptr_t bin2gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

endpackage
